/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_gain_pipe_top
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Errors found
PASS_MSG  := No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; exit 1; \
	else \
	  echo "simulation PASSED"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/gain_vectors.txt */
# columns, all hex: gain(Q4.4) sample last expected_sample expected_sat
# expected = saturate((sample * gain) >>> 4), sat set when clipped
10 0000 0 0000 0
10 0001 0 0001 0
10 7fff 0 7fff 0
10 8000 0 8000 0
10 ffff 0 ffff 0
10 1234 1 1234 0
20 1000 0 2000 0
20 4000 0 7fff 1
20 c000 0 8000 0
20 bfff 0 8000 1
08 0003 0 0001 0
08 fffd 0 fffe 0
18 0064 1 0096 0
ff 0800 0 7f80 0
ff f800 0 8080 0
ff 0810 0 7fff 1
00 5555 1 0000 0
30 0001 0 0003 0
30 0010 0 0030 0
30 0100 0 0300 0
30 1000 0 3000 0
30 2aaa 0 7ffe 0
30 2aab 0 7fff 1
30 f000 0 d000 0
30 d555 0 8000 1
30 ff00 1 fd00 0

/* dv/tb_gain_pipe_top.sv */
// Gain pipeline testbench
`timescale 1ns/1ps
`default_nettype none

module tb_gain_pipe_top;

  // vector index ranges of the test phases
  localparam int NumUnity = 6;
  localparam int FillFirst = 17;
  localparam int Places = 9;

  // one line of the vector file
  typedef struct packed {
    stream_pkg::gain_t gain;
    stream_pkg::beat_t in_beat;
    stream_pkg::beat_t exp_beat;
  } vector_t;

  logic               clock = 1'b0;
  logic               reset;
  logic               clear_i;
  stream_pkg::gain_t  gain_i;
  logic               in_valid_i;
  logic               in_ready_o;
  stream_pkg::beat_t  in_beat_i;
  logic               out_valid_o;
  logic               out_ready_i = 1'b1;
  stream_pkg::beat_t  out_beat_o;
  fifo_cfg_pkg::occ_t ingress_occ_o;
  fifo_cfg_pkg::occ_t egress_occ_o;

  vector_t           vec_q[$];
  stream_pkg::beat_t exp_q[$];
  integer            seed = 32'h7491;
  logic              stall_en = 1'b0;
  logic              sink_hold = 1'b0;
  logic              loaded = 1'b0;
  int                waited;

  gain_pipe_top uut (
    .clock        (clock),
    .reset        (reset),
    .clear_i      (clear_i),
    .gain_i       (gain_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .in_beat_i    (in_beat_i),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_beat_o   (out_beat_o),
    .ingress_occ_o(ingress_occ_o),
    .egress_occ_o (egress_occ_o)
  );

  always #10 clock = ~clock;

  // sink ready, random or held
  always @(posedge clock) begin
    #2;
    if (stall_en) begin
      out_ready_i = (($random(seed) & 3) != 0);
    end else begin
      out_ready_i = ~sink_hold;
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_beat(input stream_pkg::beat_t got, input stream_pkg::beat_t exp,
                            input string what);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0t: %s: got %h/%b/%b, expected %h/%b/%b", $time, what,
                          got.data, got.last, got.sat, exp.data, exp.last, exp.sat));
    end
  endtask

  task automatic check_occ(input fifo_cfg_pkg::occ_t got, input fifo_cfg_pkg::occ_t exp,
                           input string what);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0t: %s: got %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0t: %s: got %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  g;
    logic [15:0] s;
    logic [15:0] e;
    logic        l;
    logic        sat;
    vector_t     v;
    fd = $fopen("dv/gain_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the vector file dv/gain_vectors.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h", g, s, l, e, sat);
          if (n == 5) begin
            v.gain = g;
            v.in_beat.data = s;
            v.in_beat.last = l;
            v.in_beat.sat = 1'b0;
            v.exp_beat.data = e;
            v.exp_beat.last = l;
            v.exp_beat.sat = sat;
            vec_q.push_back(v);
          end else if (n > 0) begin
            abort_run($sformatf("malformed line in the vector file: %s", line));
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // called just after a rising edge, returns just after the accepting edge
  task automatic send_beat(input int idx, input bit expect_out, output int stalls);
    vector_t v;
    logic    taken;
    v = vec_q[idx];
    stalls = 0;
    taken = 1'b0;
    // gain is sampled on entry to the gain stage, so queued beats go first
    if (v.gain != gain_i) begin
      in_valid_i = 1'b0;
      @(negedge clock);
      while (ingress_occ_o != '0) begin
        @(negedge clock);
      end
      @(posedge clock);
      #2;
      gain_i = v.gain;
    end
    in_valid_i = 1'b1;
    in_beat_i = v.in_beat;
    while (!taken) begin
      @(negedge clock);
      taken = in_ready_o;
      @(posedge clock);
      if (!taken) begin
        stalls++;
      end
    end
    if (expect_out) begin
      exp_q.push_back(v.exp_beat);
    end
    #2;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(negedge clock);
    end
  endtask

  // output monitor, transfers happen at the following rising edge
  always @(negedge clock) begin
    if (reset && out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        abort_run("an output beat appeared while nothing was expected");
      end else begin
        check_beat(out_beat_o, exp_q.pop_front(), "output beat");
      end
    end
  end

  // watchdog
  initial begin
    int budget;
    wait (loaded);
    budget = vec_q.size() * 20 + 200;
    repeat (budget) @(posedge clock);
    abort_run($sformatf("simulation timed out after %0d clock periods", budget));
  end

  initial begin
    reset = 1'b0;
    clear_i = 1'b0;
    gain_i = 8'h10;
    in_valid_i = 1'b0;
    in_beat_i = '0;
    load_vectors();
    loaded = 1'b1;
    repeat (5) @(posedge clock);
    #2;
    reset = 1'b1;

    @(negedge clock);
    check_flag(out_valid_o, 1'b0, "out_valid after reset");
    check_flag(in_ready_o, 1'b1, "in_ready after reset");
    check_occ(ingress_occ_o, '0, "ingress occupancy after reset");
    check_occ(egress_occ_o, '0, "egress occupancy after reset");
    check_beat(out_beat_o, '0, "out_beat after reset");

    // unity gain, one beat at a time to see the latency
    for (int i = 0; i < NumUnity; i++) begin
      @(posedge clock);
      #2;
      send_beat(i, 1'b1, waited);
      in_valid_i = 1'b0;
      check_flag(waited == 0, 1'b1, "empty pipeline accepts at once");
      @(negedge clock);
      check_flag(out_valid_o, 1'b0, "out_valid while beat sits in gain stage");
      @(negedge clock);
      check_flag(out_valid_o, 1'b1, "out_valid one cycle after acceptance");
    end
    wait_drain();

    // other gains, back to back
    @(posedge clock);
    #2;
    for (int i = NumUnity; i < FillFirst; i++) begin
      send_beat(i, 1'b1, waited);
    end
    in_valid_i = 1'b0;
    wait_drain();

    // sink held low until all places are taken
    sink_hold = 1'b1;
    @(posedge clock);
    #2;
    for (int i = FillFirst; i < FillFirst + Places; i++) begin
      send_beat(i, 1'b1, waited);
      check_flag(waited == 0, 1'b1, "beat accepted while space remains");
    end
    in_valid_i = 1'b0;
    @(negedge clock);
    check_flag(in_ready_o, 1'b0, "in_ready with nine beats held");
    check_occ(egress_occ_o, fifo_cfg_pkg::occ_t'(4), "egress occupancy when full");
    check_occ(ingress_occ_o, fifo_cfg_pkg::occ_t'(4), "ingress occupancy when full");
    sink_hold = 1'b0;
    wait_drain();

    // fill again, then flush
    sink_hold = 1'b1;
    @(posedge clock);
    #2;
    for (int i = FillFirst; i < FillFirst + Places; i++) begin
      send_beat(i, 1'b0, waited);
    end
    in_valid_i = 1'b0;
    @(negedge clock);
    check_flag(in_ready_o, 1'b0, "in_ready before clear");
    @(posedge clock);
    #2;
    clear_i = 1'b1;
    @(posedge clock);
    #2;
    clear_i = 1'b0;
    @(negedge clock);
    check_occ(ingress_occ_o, '0, "ingress occupancy after clear");
    check_occ(egress_occ_o, '0, "egress occupancy after clear");
    check_flag(out_valid_o, 1'b0, "out_valid after clear");
    check_flag(in_ready_o, 1'b1, "in_ready after clear");
    check_beat(out_beat_o, '0, "out_beat after clear");
    sink_hold = 1'b0;

    // whole file with random sink stalls
    stall_en = 1'b1;
    @(posedge clock);
    #2;
    for (int i = 0; i < vec_q.size(); i++) begin
      send_beat(i, 1'b1, waited);
    end
    in_valid_i = 1'b0;
    wait_drain();
    stall_en = 1'b0;

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
rtl/stream_pkg.sv
rtl/fifo_cfg_pkg.sv
rtl/fifo_sync.sv
rtl/gain_stage.sv
rtl/gain_pipe_top.sv
dv/tb_gain_pipe_top.sv

/* rtl/fifo_cfg_pkg.sv */
// Pipeline FIFO configuration
`default_nettype none

package fifo_cfg_pkg;

  // ingress and egress buffer sizes
  localparam int unsigned IngressDepth = 4;
  localparam int unsigned EgressDepth = 4;

  // wide enough to hold a count of 0 to 4
  localparam int unsigned OccW = 3;

  // FIFO occupancy count
  typedef logic [OccW-1:0] occ_t;

endpackage

`default_nettype wire

/* rtl/fifo_sync.sv */
// Generic synchronous FIFO
`timescale 1ns/1ps
`default_nettype none

module fifo_sync #(
  parameter int unsigned Width = 16,
  // let a write pass straight to the read port when empty
  parameter bit Pass = 1'b1,
  parameter int unsigned Depth = 4,
  // drive zero on rdata_o whenever nothing is valid
  parameter bit OutputZeroIfEmpty = 1'b1
) (
  input  logic               clock,
  input  logic               reset,
  // synchronous flush
  input  logic               clr_i,
  // write port
  input  logic               wvalid_i,
  output logic               wready_o,
  input  logic [Width-1:0]   wdata_i,
  // read port
  output logic               rvalid_o,
  input  logic               rready_i,
  output logic [Width-1:0]   rdata_o,
  // entries held
  output fifo_cfg_pkg::occ_t depth_o
);

  if (Depth == 0) begin : gen_passthru
    // no storage, straight wires in both directions
    assign depth_o = '0;
    assign rvalid_o = wvalid_i;
    assign rdata_o = wdata_i;
    assign wready_o = rready_i;
  end else begin : gen_fifo
    localparam int unsigned PtrVW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned PtrW = PtrVW + 1;
    localparam logic [PtrVW-1:0] LastIdx = PtrVW'(Depth - 1);

    logic [PtrW-1:0]  wptr_q;
    logic [PtrW-1:0]  rptr_q;
    logic [PtrVW-1:0] wptr_idx;
    logic [PtrVW-1:0] rptr_idx;
    logic             push;
    logic             pop;
    logic             full;
    logic             fifo_empty;
    logic             empty;
    logic [Width-1:0] storage [Depth];
    logic [Width-1:0] storage_rdata;
    logic [Width-1:0] rdata_int;

    // advance a pointer, flipping the wrap bit past the last entry
    function automatic logic [PtrW-1:0] ptr_incr(input logic [PtrW-1:0] ptr);
      if (ptr[PtrVW-1:0] == LastIdx) begin
        return {~ptr[PtrW-1], {PtrVW{1'b0}}};
      end
      return ptr + PtrW'(1);
    endfunction

    assign wptr_idx = wptr_q[PtrVW-1:0];
    assign rptr_idx = rptr_q[PtrVW-1:0];

    // same index, different wrap bit means full
    assign full = (wptr_q[PtrW-1] != rptr_q[PtrW-1]) && (wptr_idx == rptr_idx);
    assign fifo_empty = (wptr_q == rptr_q);

    assign wready_o = ~full;
    assign rvalid_o = ~empty;
    assign push = wvalid_i & ~full;
    assign pop = rvalid_o & rready_i;

    always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
        wptr_q <= '0;
        rptr_q <= '0;
      end else if (clr_i) begin
        wptr_q <= '0;
        rptr_q <= '0;
      end else begin
        if (push) begin
          wptr_q <= ptr_incr(wptr_q);
        end
        if (pop) begin
          rptr_q <= ptr_incr(rptr_q);
        end
      end
    end

    // occupancy from the pointer difference
    always_comb begin
      if (wptr_q[PtrW-1] == rptr_q[PtrW-1]) begin
        depth_o = fifo_cfg_pkg::occ_t'(wptr_idx) - fifo_cfg_pkg::occ_t'(rptr_idx);
      end else begin
        depth_o = fifo_cfg_pkg::occ_t'(Depth) - fifo_cfg_pkg::occ_t'(rptr_idx)
                  + fifo_cfg_pkg::occ_t'(wptr_idx);
      end
    end

    if (Depth == 1) begin : gen_one_entry
      assign storage_rdata = storage[0];

      always_ff @(posedge clock) begin
        if (push) begin
          storage[0] <= wdata_i;
        end
      end
    end else begin : gen_many_entries
      assign storage_rdata = storage[rptr_idx];

      always_ff @(posedge clock) begin
        if (push) begin
          storage[wptr_idx] <= wdata_i;
        end
      end
    end

    if (Pass) begin : gen_pass
      // an empty FIFO forwards the incoming write
      assign rdata_int = (fifo_empty && wvalid_i) ? wdata_i : storage_rdata;
      assign empty = fifo_empty & ~wvalid_i;
    end else begin : gen_no_pass
      assign rdata_int = storage_rdata;
      assign empty = fifo_empty;
    end

    if (OutputZeroIfEmpty) begin : gen_zero_out
      assign rdata_o = empty ? '0 : rdata_int;
    end else begin : gen_raw_out
      assign rdata_o = rdata_int;
    end
  end

endmodule

`default_nettype wire

/* rtl/gain_pipe_top.sv */
// Streaming sample gain pipeline
`timescale 1ns/1ps
`default_nettype none

module gain_pipe_top (
  input  logic               clock,
  input  logic               reset,
  input  logic               clear_i,
  input  stream_pkg::gain_t  gain_i,
  // sample source
  input  logic               in_valid_i,
  output logic               in_ready_o,
  input  stream_pkg::beat_t  in_beat_i,
  // sample sink
  output logic               out_valid_o,
  input  logic               out_ready_i,
  output stream_pkg::beat_t  out_beat_o,
  // buffer levels
  output fifo_cfg_pkg::occ_t ingress_occ_o,
  output fifo_cfg_pkg::occ_t egress_occ_o
);

  logic              ingress_valid;
  logic              ingress_ready;
  stream_pkg::beat_t ingress_beat;
  logic              gain_valid;
  logic              gain_ready;
  stream_pkg::beat_t gain_beat;

  // ingress passes beats straight through while empty
  fifo_sync #(
    .Width            (stream_pkg::BeatW),
    .Pass             (1'b1),
    .Depth            (fifo_cfg_pkg::IngressDepth),
    .OutputZeroIfEmpty(1'b0)
  ) u_ingress (
    .clock   (clock),
    .reset   (reset),
    .clr_i   (clear_i),
    .wvalid_i(in_valid_i),
    .wready_o(in_ready_o),
    .wdata_i (in_beat_i),
    .rvalid_o(ingress_valid),
    .rready_i(ingress_ready),
    .rdata_o (ingress_beat),
    .depth_o (ingress_occ_o)
  );

  gain_stage u_gain (
    .clock      (clock),
    .reset      (reset),
    .clear_i    (clear_i),
    .gain_i     (gain_i),
    .in_valid_i (ingress_valid),
    .in_ready_o (ingress_ready),
    .in_beat_i  (ingress_beat),
    .out_valid_o(gain_valid),
    .out_ready_i(gain_ready),
    .out_beat_o (gain_beat)
  );

  // egress registers every beat and shows zero when empty
  fifo_sync #(
    .Width            (stream_pkg::BeatW),
    .Pass             (1'b0),
    .Depth            (fifo_cfg_pkg::EgressDepth),
    .OutputZeroIfEmpty(1'b1)
  ) u_egress (
    .clock   (clock),
    .reset   (reset),
    .clr_i   (clear_i),
    .wvalid_i(gain_valid),
    .wready_o(gain_ready),
    .wdata_i (gain_beat),
    .rvalid_o(out_valid_o),
    .rready_i(out_ready_i),
    .rdata_o (out_beat_o),
    .depth_o (egress_occ_o)
  );

endmodule

`default_nettype wire

/* rtl/gain_stage.sv */
// Sample gain and saturation stage
`timescale 1ns/1ps
`default_nettype none

module gain_stage (
  input  logic              clock,
  input  logic              reset,
  input  logic              clear_i,
  input  stream_pkg::gain_t gain_i,
  // upstream side
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  stream_pkg::beat_t in_beat_i,
  // downstream side
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output stream_pkg::beat_t out_beat_o
);

  logic              valid_q;
  stream_pkg::beat_t beat_q;
  stream_pkg::beat_t beat_d;
  stream_pkg::prod_t product;
  stream_pkg::prod_t scaled;
  logic              accept;
  logic              overflow;

  // full-precision product, gain treated as non-negative
  assign product = stream_pkg::prod_t'(in_beat_i.data)
                   * stream_pkg::prod_t'({1'b0, gain_i});
  assign scaled = product >>> stream_pkg::GainFrac;

  // out of range unless all bits above the sample sign bit match it
  assign overflow = (scaled[stream_pkg::ProdW-1:stream_pkg::SampleW-1] != '0) &&
                    (scaled[stream_pkg::ProdW-1:stream_pkg::SampleW-1] != '1);

  always_comb begin
    beat_d.last = in_beat_i.last;
    beat_d.sat = overflow;
    if (!overflow) begin
      beat_d.data = scaled[stream_pkg::SampleW-1:0];
    end else if (scaled[stream_pkg::ProdW-1]) begin
      beat_d.data = stream_pkg::SampleMin;
    end else begin
      beat_d.data = stream_pkg::SampleMax;
    end
  end

  // room when empty or when the held beat leaves this cycle
  assign in_ready_o = ~valid_q | out_ready_i;
  assign accept = in_valid_i & in_ready_o;

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      valid_q <= 1'b0;
    end else if (clear_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      beat_q <= beat_d;
    end
  end

  assign out_valid_o = valid_q;
  assign out_beat_o = beat_q;

endmodule

`default_nettype wire

/* rtl/stream_pkg.sv */
// Sample stream datapath types
`default_nettype none

package stream_pkg;

  // sample and gain widths
  localparam int unsigned SampleW = 16;
  localparam int unsigned GainW = 8;

  // gain is Q4.4, so 16 is unity
  localparam int unsigned GainFrac = 4;

  // signed sample times zero-extended gain
  localparam int unsigned ProdW = SampleW + GainW + 1;

  // signed sample word
  typedef logic signed [SampleW-1:0] sample_t;

  // unsigned fixed-point gain
  typedef logic [GainW-1:0] gain_t;

  // full-precision product before saturation
  typedef logic signed [ProdW-1:0] prod_t;

  // one beat on every valid/ready link
  typedef struct packed {
    sample_t data;
    logic    last;
    // set when the gain stage clipped the result
    logic    sat;
  } beat_t;

  localparam int unsigned BeatW = $bits(beat_t);

  // saturation limits of sample_t
  localparam sample_t SampleMax = {1'b0, {(SampleW-1){1'b1}}};
  localparam sample_t SampleMin = {1'b1, {(SampleW-1){1'b0}}};

endpackage

`default_nettype wire
